/* dsp_mac_top.f */
hdl/dsp_pkg.sv
hdl/dsp_input_stage.sv
hdl/dsp_multiplier.sv
hdl/dsp_accumulator.sv
hdl/dsp_output_stage.sv
hdl/dsp_mac_top.sv
bench/tb_dsp_mac.sv

/* bench/tb_dsp_mac.sv */
/*
 * Testbench for dsp_mac_top
 * Reference model, random and directed items, output checks and watchdog
 */
`timescale 1ns/10ps
`default_nettype none

module tb_dsp_mac;

    localparam int CLK_PERIOD = 8;
    // Items per phase for product, accumulate, shift and saturation
    localparam int STIM_ITEMS = 40 + 29 + 131 + 64;
    localparam int MARGIN = 40;

    logic                            clock_i = 1'b0;
    logic                            s_reset;
    logic [dsp_pkg::NBITS_A-1:0]     a_i;
    logic [dsp_pkg::NBITS_B-1:0]     b_i;
    logic                            unsigned_a_i;
    logic                            unsigned_b_i;
    dsp_pkg::fb_mode_t               feedback_i;
    logic                            load_acc_i;
    logic                            subtract_i;
    logic [dsp_pkg::NBITS_SHIFT-1:0] shift_right_i;
    logic                            round_i;
    logic                            saturate_enable_i;
    dsp_pkg::out_sel_t               out_sel_i;
    wire  [dsp_pkg::NBITS_Z-1:0]     z_o;

    logic [31:0]                     rng_state = 32'd4024;
    logic [dsp_pkg::NBITS_ACC-1:0]   model_acc = '0;
    logic [dsp_pkg::NBITS_Z-1:0]     exp_now = '0;
    logic [dsp_pkg::NBITS_Z-1:0]     exp_z = '0;
    logic [dsp_pkg::NBITS_Z-1:0]     exp_q[$];
    int                              check_count = 0;
    int                              err_count = 0;

    always #(CLK_PERIOD / 2) clock_i = ~clock_i;

    dsp_mac_top UUT (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .a_i(a_i),
        .b_i(b_i),
        .unsigned_a_i(unsigned_a_i),
        .unsigned_b_i(unsigned_b_i),
        .feedback_i(feedback_i),
        .load_acc_i(load_acc_i),
        .subtract_i(subtract_i),
        .shift_right_i(shift_right_i),
        .round_i(round_i),
        .saturate_enable_i(saturate_enable_i),
        .out_sel_i(out_sel_i),
        .z_o(z_o)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Full product at accumulator width
    function automatic logic [63:0] product_of(input logic [dsp_pkg::NBITS_A-1:0] a,
                                               input logic [dsp_pkg::NBITS_B-1:0] b,
                                               input logic ua, input logic ub);
        logic [63:0] ea;
        logic [63:0] eb;
        longint      sa;
        longint      sb;
        ea = a;
        eb = b;
        if (ua && ub) begin
            return ea * eb;
        end
        if (ua) sa = ea;
        else sa = $signed(a);
        if (ub) sb = eb;
        else sb = $signed(b);
        return sa * sb;
    endfunction

    function automatic logic [dsp_pkg::NBITS_Z-1:0] shaped_acc(input logic [63:0] acc,
        input logic [5:0] sh, input logic rnd, input logic sat, input logic umode);
        longint                     v;
        longint                     smax;
        longint                     umax;
        logic [dsp_pkg::NBITS_Z-1:0] z;
        smax = (longint'(1) <<< (dsp_pkg::NBITS_Z - 1)) - 1;
        umax = (longint'(1) <<< dsp_pkg::NBITS_Z) - 1;
        v = $signed(acc) >>> sh;
        if (rnd && sh != 0 && acc[sh - 1]) v = v + 1;
        z = v[dsp_pkg::NBITS_Z-1:0];
        if (sat && umode) begin
            if (v < 0) z = '0;
            else if (v > umax) z = '1;
        end else if (sat) begin
            if (v > smax) z = {1'b0, {(dsp_pkg::NBITS_Z-1){1'b1}}};
            else if (v < -smax - 1) z = {1'b1, {(dsp_pkg::NBITS_Z-1){1'b0}}};
        end
        return z;
    endfunction

    // Drive one item and run it through the model
    task automatic apply_item(input logic [dsp_pkg::NBITS_A-1:0] a,
        input logic [dsp_pkg::NBITS_B-1:0] b, input logic ua, input logic ub,
        input dsp_pkg::fb_mode_t fb, input logic load, input logic sub,
        input logic [5:0] sh, input logic rnd, input logic sat, input dsp_pkg::out_sel_t osel);
        logic [63:0] p;
        logic [63:0] addend;
        @(negedge clock_i);
        a_i = a;
        b_i = b;
        unsigned_a_i = ua;
        unsigned_b_i = ub;
        feedback_i = fb;
        load_acc_i = load;
        subtract_i = sub;
        shift_right_i = sh;
        round_i = rnd;
        saturate_enable_i = sat;
        out_sel_i = osel;
        p = product_of(a, b, ua, ub);
        addend = sub ? -p : p;
        if (load) begin
            model_acc = ((fb == dsp_pkg::FB_RESTART) ? 64'd0 : model_acc) + addend;
        end
        if (osel == dsp_pkg::OUT_PRODUCT) exp_now = p[dsp_pkg::NBITS_Z-1:0];
        else exp_now = shaped_acc(model_acc, sh, rnd, sat, ua && ub);
    endtask

    // Expected values line up with z_o after PIPE_LATENCY edges
    always @(posedge clock_i) begin
        if (s_reset) begin
            exp_q.delete();
            exp_z <= '0;
        end else begin
            exp_q.push_back(exp_now);
            if (exp_q.size() == dsp_pkg::PIPE_LATENCY) exp_z <= exp_q.pop_front();
        end
    end

    a_z_match: assert property (@(posedge clock_i) disable iff (s_reset) z_o == exp_z)
        check_count++;
    else begin
        err_count++;
        $display("ERR z_o expected %h actual %h at %0t", $sampled(exp_z), $sampled(z_o), $time);
    end

    a_z_known: assert property (@(posedge clock_i) disable iff (s_reset) !$isunknown(z_o))
    else begin
        err_count++;
        $display("z_o has unknown bits at %0t", $time);
    end

    initial begin
        #((STIM_ITEMS + MARGIN) * CLK_PERIOD);
        $display("Timeout, the stimulus did not complete in the expected time");
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] q;
        s_reset = 1'b1;
        a_i = '0;
        b_i = '0;
        unsigned_a_i = 1'b0;
        unsigned_b_i = 1'b0;
        feedback_i = dsp_pkg::FB_ACCUMULATE;
        load_acc_i = 1'b0;
        subtract_i = 1'b0;
        shift_right_i = '0;
        round_i = 1'b0;
        saturate_enable_i = 1'b0;
        out_sel_i = dsp_pkg::OUT_PRODUCT;
        repeat (2) @(posedge clock_i);
        @(negedge clock_i);
        s_reset = 1'b0;

        // Products under all four signedness combinations
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            q = next_rand();
            apply_item(r[19:0], q[17:0], i[0], i[1], dsp_pkg::FB_RESTART, 1'b0, 1'b0,
                       6'd0, 1'b0, 1'b0, dsp_pkg::OUT_PRODUCT);
        end

        // Running sum followed by a hold with load_acc low
        for (int i = 0; i < 29; i++) begin
            r = next_rand();
            q = next_rand();
            apply_item(r[19:0], q[17:0], 1'b0, 1'b0,
                       (i == 0) ? dsp_pkg::FB_RESTART : dsp_pkg::FB_ACCUMULATE,
                       i < 21, r[31] && i != 0, 6'd0, 1'b0, 1'b0, dsp_pkg::OUT_ACCUMULATOR);
        end

        // Every shift amount, with and without rounding
        for (int sh = 0; sh < 64; sh++) begin
            for (int rnd = 0; rnd < 2; rnd++) begin
                r = next_rand();
                q = next_rand();
                apply_item(r[19:0], q[17:0], 1'b0, 1'b0, dsp_pkg::FB_RESTART, 1'b1, q[31],
                           sh[5:0], rnd[0], 1'b0, dsp_pkg::OUT_ACCUMULATOR);
            end
        end
        // Rounding carry ripples through the low bits
        apply_item(20'h003FF, 18'h1, 1'b0, 1'b0, dsp_pkg::FB_RESTART, 1'b1, 1'b0,
                   6'd1, 1'b1, 1'b0, dsp_pkg::OUT_ACCUMULATOR);
        apply_item(20'hFFFFF, 18'h1, 1'b0, 1'b0, dsp_pkg::FB_RESTART, 1'b1, 1'b0,
                   6'd1, 1'b1, 1'b0, dsp_pkg::OUT_ACCUMULATOR);
        apply_item(20'h7FFFF, 18'h1FFFF, 1'b0, 1'b0, dsp_pkg::FB_RESTART, 1'b1, 1'b0,
                   6'd8, 1'b1, 1'b0, dsp_pkg::OUT_ACCUMULATOR);

        // Grow past 38 bits in both directions with and without clamping
        for (int sat = 1; sat >= 0; sat--) begin
            for (int um = 0; um < 2; um++) begin
                for (int sub = 0; sub < 2; sub++) begin
                    for (int j = 0; j < 8; j++) begin
                        apply_item(um ? 20'hFFFFF : 20'h80000, um ? 18'h3FFFF : 18'h20000,
                                   um[0], um[0],
                                   (j == 0) ? dsp_pkg::FB_RESTART : dsp_pkg::FB_ACCUMULATE,
                                   1'b1, sub[0], 6'd0, 1'b0, sat[0],
                                   dsp_pkg::OUT_ACCUMULATOR);
                    end
                end
            end
        end

        // Flush the pipeline
        repeat (dsp_pkg::PIPE_LATENCY + 1) begin
            apply_item('0, '0, 1'b0, 1'b0, dsp_pkg::FB_ACCUMULATE, 1'b0, 1'b0,
                       6'd0, 1'b0, 1'b0, dsp_pkg::OUT_PRODUCT);
        end
        repeat (2) @(posedge clock_i);
        @(negedge clock_i);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/dsp_mac_top.sv */
/*
 * MAC slice top level, input stage to output register
 */
`timescale 1ns/10ps
`default_nettype none

module dsp_mac_top (
    input  wire                               clock_i,
    input  wire                               s_reset,
    input  wire [dsp_pkg::NBITS_A-1:0]        a_i,
    input  wire [dsp_pkg::NBITS_B-1:0]        b_i,
    input  wire                               unsigned_a_i,
    input  wire                               unsigned_b_i,
    input  wire dsp_pkg::fb_mode_t            feedback_i,
    input  wire                               load_acc_i,
    input  wire                               subtract_i,
    input  wire [dsp_pkg::NBITS_SHIFT-1:0]    shift_right_i,
    input  wire                               round_i,
    input  wire                               saturate_enable_i,
    input  wire dsp_pkg::out_sel_t            out_sel_i,
    output wire [dsp_pkg::NBITS_Z-1:0]        z_o
);

    // Registered item
    wire [dsp_pkg::NBITS_A-1:0]     r_a;
    wire [dsp_pkg::NBITS_B-1:0]     r_b;
    wire                            r_unsigned_a;
    wire                            r_unsigned_b;
    wire dsp_pkg::fb_mode_t         r_feedback;
    wire                            r_load_acc;
    wire                            r_subtract;
    wire [dsp_pkg::NBITS_SHIFT-1:0] r_shift;
    wire                            r_round;
    wire                            r_saturate;
    wire dsp_pkg::out_sel_t         r_out_sel;

    wire [dsp_pkg::NBITS_ACC-1:0]   product_xtnd;
    wire                            unsigned_mode;

    // Accumulator stage outputs
    wire [dsp_pkg::NBITS_ACC-1:0]   acc_q;
    wire [dsp_pkg::NBITS_ACC-1:0]   prod_q;
    wire [dsp_pkg::NBITS_SHIFT-1:0] shift_d;
    wire                            round_d;
    wire                            saturate_d;
    wire                            unsigned_mode_d;
    wire dsp_pkg::out_sel_t         out_sel_d;

    dsp_input_stage u_input (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .a_i(a_i),
        .b_i(b_i),
        .unsigned_a_i(unsigned_a_i),
        .unsigned_b_i(unsigned_b_i),
        .feedback_i(feedback_i),
        .load_acc_i(load_acc_i),
        .subtract_i(subtract_i),
        .shift_right_i(shift_right_i),
        .round_i(round_i),
        .saturate_enable_i(saturate_enable_i),
        .out_sel_i(out_sel_i),
        .a_o(r_a),
        .b_o(r_b),
        .unsigned_a_o(r_unsigned_a),
        .unsigned_b_o(r_unsigned_b),
        .feedback_o(r_feedback),
        .load_acc_o(r_load_acc),
        .subtract_o(r_subtract),
        .shift_o(r_shift),
        .round_o(r_round),
        .saturate_o(r_saturate),
        .out_sel_o(r_out_sel)
    );

    dsp_multiplier u_mult (
        .a_i(r_a),
        .b_i(r_b),
        .unsigned_a_i(r_unsigned_a),
        .unsigned_b_i(r_unsigned_b),
        .product_xtnd_o(product_xtnd),
        .unsigned_mode_o(unsigned_mode)
    );

    dsp_accumulator u_acc (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .product_xtnd_i(product_xtnd),
        .unsigned_mode_i(unsigned_mode),
        .feedback_i(r_feedback),
        .load_acc_i(r_load_acc),
        .subtract_i(r_subtract),
        .shift_i(r_shift),
        .round_i(r_round),
        .saturate_i(r_saturate),
        .out_sel_i(r_out_sel),
        .acc_o(acc_q),
        .prod_o(prod_q),
        .shift_o(shift_d),
        .round_o(round_d),
        .saturate_o(saturate_d),
        .unsigned_mode_o(unsigned_mode_d),
        .out_sel_o(out_sel_d)
    );

    dsp_output_stage u_output (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .acc_i(acc_q),
        .prod_i(prod_q),
        .shift_i(shift_d),
        .round_i(round_d),
        .saturate_i(saturate_d),
        .unsigned_mode_i(unsigned_mode_d),
        .out_sel_i(out_sel_d),
        .z_o(z_o)
    );

endmodule

`default_nettype wire

/* hdl/dsp_output_stage.sv */
/*
 * Shift, round, saturate, output select and output register
 */
`timescale 1ns/10ps
`default_nettype none

module dsp_output_stage (
    input  wire                              clock_i,
    input  wire                              s_reset,
    input  wire [dsp_pkg::NBITS_ACC-1:0]     acc_i,
    input  wire [dsp_pkg::NBITS_ACC-1:0]     prod_i,
    input  wire [dsp_pkg::NBITS_SHIFT-1:0]   shift_i,
    input  wire                              round_i,
    input  wire                              saturate_i,
    input  wire                              unsigned_mode_i,
    input  wire dsp_pkg::out_sel_t           out_sel_i,
    output logic [dsp_pkg::NBITS_Z-1:0]      z_o
);

    wire [dsp_pkg::NBITS_ACC-1:0]   acc_shr;
    wire [dsp_pkg::NBITS_SHIFT-1:0] rnd_idx;
    wire                            rnd_up;
    wire [dsp_pkg::NBITS_ACC-1:0]   acc_rnd;
    wire                            rnd_neg;
    wire                            u_over;
    wire                            s_fits;
    logic [dsp_pkg::NBITS_Z-1:0]    acc_sat;
    wire [dsp_pkg::NBITS_Z-1:0]     z_next;

    assign acc_shr = $signed(acc_i) >>> shift_i;

    // Round half up on the last bit shifted out
    assign rnd_idx = shift_i - 1'b1;
    assign rnd_up = round_i && (shift_i != '0) && acc_i[rnd_idx];
    assign acc_rnd = acc_shr + {{(dsp_pkg::NBITS_ACC-1){1'b0}}, rnd_up};

    assign rnd_neg = acc_rnd[dsp_pkg::NBITS_ACC-1];

    // Unsigned overflow is anything above bit 37
    assign u_over = |acc_rnd[dsp_pkg::NBITS_ACC-1:dsp_pkg::NBITS_Z];

    // Signed fits when bits 63..37 agree
    assign s_fits = (&acc_rnd[dsp_pkg::NBITS_ACC-1:dsp_pkg::NBITS_Z-1]) ||
                    !(|acc_rnd[dsp_pkg::NBITS_ACC-1:dsp_pkg::NBITS_Z-1]);

    always_comb begin
        acc_sat = acc_rnd[dsp_pkg::NBITS_Z-1:0];
        if (saturate_i) begin
            if (unsigned_mode_i) begin
                if (rnd_neg) begin
                    acc_sat = '0;
                end else if (u_over) begin
                    acc_sat = '1;
                end
            end else if (!s_fits) begin
                acc_sat = {rnd_neg, {(dsp_pkg::NBITS_Z-1){~rnd_neg}}};
            end
        end
    end

    assign z_next = (out_sel_i == dsp_pkg::OUT_PRODUCT) ? prod_i[dsp_pkg::NBITS_Z-1:0] :
                                                           acc_sat;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_o <= '0;
        end else begin
            z_o <= z_next;
        end
    end

    // Signed clamp never flips the sign of the rounded accumulator
    a_sat_sign: assert property (@(posedge clock_i) disable iff (s_reset)
        (saturate_i && !unsigned_mode_i && out_sel_i == dsp_pkg::OUT_ACCUMULATOR)
        |=> z_o[dsp_pkg::NBITS_Z-1] == $past(acc_rnd[dsp_pkg::NBITS_ACC-1]))
        else $error("output stage: signed saturation lost the sign");

endmodule

`default_nettype wire

/* hdl/dsp_accumulator.sv */
/*
 * Add/subtract, feedback select and 64-bit accumulator register
 */
`timescale 1ns/10ps
`default_nettype none

module dsp_accumulator (
    input  wire                                clock_i,
    input  wire                                s_reset,
    input  wire [dsp_pkg::NBITS_ACC-1:0]       product_xtnd_i,
    input  wire                                unsigned_mode_i,
    input  wire dsp_pkg::fb_mode_t             feedback_i,
    input  wire                                load_acc_i,
    input  wire                                subtract_i,
    input  wire [dsp_pkg::NBITS_SHIFT-1:0]     shift_i,
    input  wire                                round_i,
    input  wire                                saturate_i,
    input  wire dsp_pkg::out_sel_t             out_sel_i,
    output logic [dsp_pkg::NBITS_ACC-1:0]      acc_o,
    output logic [dsp_pkg::NBITS_ACC-1:0]      prod_o,
    output logic [dsp_pkg::NBITS_SHIFT-1:0]    shift_o,
    output logic                               round_o,
    output logic                               saturate_o,
    output logic                               unsigned_mode_o,
    output dsp_pkg::out_sel_t                  out_sel_o
);

    wire [dsp_pkg::NBITS_ACC-1:0] addend;
    wire [dsp_pkg::NBITS_ACC-1:0] fb_term;
    wire [dsp_pkg::NBITS_ACC-1:0] sum;

    // Two's complement negate on subtract
    assign addend = subtract_i ? (~product_xtnd_i + 1'b1) : product_xtnd_i;

    assign fb_term = (feedback_i == dsp_pkg::FB_RESTART) ? '0 : acc_o;
    assign sum = addend + fb_term;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc_o <= '0;
        end else if (load_acc_i) begin
            acc_o <= sum;
        end
    end

    // Keep product and output controls aligned with acc_o
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            prod_o          <= '0;
            shift_o         <= '0;
            round_o         <= 1'b0;
            saturate_o      <= 1'b0;
            unsigned_mode_o <= 1'b0;
            out_sel_o       <= dsp_pkg::OUT_PRODUCT;
        end else begin
            prod_o          <= product_xtnd_i;
            shift_o         <= shift_i;
            round_o         <= round_i;
            saturate_o      <= saturate_i;
            unsigned_mode_o <= unsigned_mode_i;
            out_sel_o       <= out_sel_i;
        end
    end

    a_acc_hold: assert property (@(posedge clock_i) disable iff (s_reset)
        !load_acc_i |=> $stable(acc_o))
        else $error("accumulator: acc_o changed without load_acc");

endmodule

`default_nettype wire

/* hdl/dsp_multiplier.sv */
/*
 * 20x18 signed/unsigned multiplier with extension to accumulator width
 */
`timescale 1ns/10ps
`default_nettype none

module dsp_multiplier (
    input  wire [dsp_pkg::NBITS_A-1:0]   a_i,
    input  wire [dsp_pkg::NBITS_B-1:0]   b_i,
    input  wire                          unsigned_a_i,
    input  wire                          unsigned_b_i,
    output wire [dsp_pkg::NBITS_ACC-1:0] product_xtnd_o,
    output wire                          unsigned_mode_o
);

    wire                          neg_a;
    wire                          neg_b;
    wire                          neg_p;
    wire [dsp_pkg::NBITS_A-1:0]   mag_a;
    wire [dsp_pkg::NBITS_B-1:0]   mag_b;
    wire [dsp_pkg::NBITS_P-1:0]   mag_p;
    wire [dsp_pkg::NBITS_P-1:0]   product;

    assign unsigned_mode_o = unsigned_a_i & unsigned_b_i;

    // Operand is negative only when treated as signed
    assign neg_a = a_i[dsp_pkg::NBITS_A-1] & ~unsigned_a_i;
    assign neg_b = b_i[dsp_pkg::NBITS_B-1] & ~unsigned_b_i;
    assign neg_p = neg_a ^ neg_b;

    // Most negative value maps onto its unsigned pattern
    assign mag_a = neg_a ? (~a_i + 1'b1) : a_i;
    assign mag_b = neg_b ? (~b_i + 1'b1) : b_i;
    assign mag_p = mag_a * mag_b;

    // Unsigned mode keeps both magnitudes equal to the raw operands
    assign product = neg_p ? (~mag_p + 1'b1) : mag_p;

    assign product_xtnd_o = unsigned_mode_o ?
        {{(dsp_pkg::NBITS_ACC-dsp_pkg::NBITS_P){1'b0}}, product} :
        {{(dsp_pkg::NBITS_ACC-dsp_pkg::NBITS_P){product[dsp_pkg::NBITS_P-1]}}, product};

endmodule

`default_nettype wire

/* hdl/dsp_input_stage.sv */
/*
 * Input registers for operands and per-item controls
 */
`timescale 1ns/10ps
`default_nettype none

module dsp_input_stage (
    input  wire                                clock_i,
    input  wire                                s_reset,
    input  wire [dsp_pkg::NBITS_A-1:0]         a_i,
    input  wire [dsp_pkg::NBITS_B-1:0]         b_i,
    input  wire                                unsigned_a_i,
    input  wire                                unsigned_b_i,
    input  wire dsp_pkg::fb_mode_t             feedback_i,
    input  wire                                load_acc_i,
    input  wire                                subtract_i,
    input  wire [dsp_pkg::NBITS_SHIFT-1:0]     shift_right_i,
    input  wire                                round_i,
    input  wire                                saturate_enable_i,
    input  wire dsp_pkg::out_sel_t             out_sel_i,
    output logic [dsp_pkg::NBITS_A-1:0]        a_o,
    output logic [dsp_pkg::NBITS_B-1:0]        b_o,
    output logic                               unsigned_a_o,
    output logic                               unsigned_b_o,
    output dsp_pkg::fb_mode_t                  feedback_o,
    output logic                               load_acc_o,
    output logic                               subtract_o,
    output logic [dsp_pkg::NBITS_SHIFT-1:0]    shift_o,
    output logic                               round_o,
    output logic                               saturate_o,
    output dsp_pkg::out_sel_t                  out_sel_o
);

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            a_o          <= '0;
            b_o          <= '0;
            unsigned_a_o <= 1'b0;
            unsigned_b_o <= 1'b0;
            feedback_o   <= dsp_pkg::FB_ACCUMULATE;
            load_acc_o   <= 1'b0;
            subtract_o   <= 1'b0;
            shift_o      <= '0;
            round_o      <= 1'b0;
            saturate_o   <= 1'b0;
            out_sel_o    <= dsp_pkg::OUT_PRODUCT;
        end else begin
            a_o          <= a_i;
            b_o          <= b_i;
            unsigned_a_o <= unsigned_a_i;
            unsigned_b_o <= unsigned_b_i;
            feedback_o   <= feedback_i;
            load_acc_o   <= load_acc_i;
            subtract_o   <= subtract_i;
            shift_o      <= shift_right_i;
            round_o      <= round_i;
            saturate_o   <= saturate_enable_i;
            out_sel_o    <= out_sel_i;
        end
    end

    // X on a control poisons every later result
    a_ctrl_known: assert property (@(posedge clock_i) disable iff (s_reset)
        !$isunknown({unsigned_a_o, unsigned_b_o, feedback_o, load_acc_o, subtract_o,
                     shift_o, round_o, saturate_o, out_sel_o}))
        else $error("input stage: registered control is unknown");

endmodule

`default_nettype wire

/* hdl/dsp_pkg.sv */
/*
 * Widths, pipeline depth and mode enums shared by the MAC slice
 */
`default_nettype none

package dsp_pkg;

    // Operand widths
    localparam int NBITS_A = 20;
    localparam int NBITS_B = 18;

    // Full product, no growth lost
    localparam int NBITS_P = NBITS_A + NBITS_B;

    localparam int NBITS_ACC = 64;
    localparam int NBITS_Z = 38;
    localparam int NBITS_SHIFT = 6;

    // Edges from input capture to z_o
    localparam int PIPE_LATENCY = 3;

    // Second adder operand
    typedef enum logic [0:0] {
        FB_ACCUMULATE = 1'b0,
        FB_RESTART    = 1'b1
    } fb_mode_t;

    // What z_o shows
    typedef enum logic [0:0] {
        OUT_PRODUCT     = 1'b0,
        OUT_ACCUMULATOR = 1'b1
    } out_sel_t;

endpackage

`default_nettype wire
